//--- board_cfg.sv
`timescale 1ns/1ps
`include "board_defines.svh"

module board_cfg import board_pkg::*; (
	input logic dspclk,
	input logic reset,
	input logic [`FREQ_CHANNELS-1:0] fin,
	input logic soft_reset_stb,
	input logic coef_wstb,
	input logic [`COEF_ADDR_WIDTH-1:0] coef_waddr,
	input coef_word_t coef_wdata,
	input logic [`COEF_ADDR_WIDTH-1:0] coef_raddr,
	input logic in_stb,
	input logic [`COEF_DIM*`SAMPLE_WIDTH-1:0] in_data,
	output logic dsp_reset,
	output coef_word_t coef_rdata,
	output logic busy,
	output logic out_stb,
	output logic [`COEF_DIM*`SAMPLE_WIDTH-1:0] out_data,
	output logic freq_stb,
	output logic [`FREQ_CHANNELS*`FREQ_WIDTH-1:0] freq_data
);

	// mixer side of the coefficient bank
	logic [`COEF_ADDR_WIDTH-1:0] mix_raddr;
	coef_word_t mix_rdata;

	reset_stretch reset_stretch_inst (
		.dspclk(dspclk),
		.reset(reset),
		.soft_reset_stb(soft_reset_stb),
		.dsp_reset(dsp_reset)
	);

	freq_meter freq_meter_inst (
		.dspclk(dspclk),
		.reset(reset),
		.fin(fin),
		.freq_stb(freq_stb),
		.freq_data(freq_data)
	);

	// coefficients survive a soft reset, only the board reset restores identity
	coef_bank coef_bank_inst (
		.dspclk(dspclk),
		.reset(reset),
		.coef_wstb(coef_wstb),
		.coef_waddr(coef_waddr),
		.coef_wdata(coef_wdata),
		.mix_raddr(mix_raddr),
		.mix_rdata(mix_rdata),
		.coef_raddr(coef_raddr),
		.coef_rdata(coef_rdata)
	);

	chan_mixer chan_mixer_inst (
		.dspclk(dspclk),
		.dsp_reset(dsp_reset),
		.in_stb(in_stb),
		.in_data(in_data),
		.busy(busy),
		.mix_raddr(mix_raddr),
		.mix_rdata(mix_rdata),
		.out_stb(out_stb),
		.out_data(out_data)
	);

endmodule

//--- board_defines.svh
`ifndef BOARD_DEFINES_SVH
`define BOARD_DEFINES_SVH

// coefficient matrix is COEF_DIM x COEF_DIM, one frame holds COEF_DIM samples
`define COEF_DIM 8
// row-major address, row * COEF_DIM + column
`define COEF_ADDR_WIDTH 6

// signed samples in and out of the mixer
`define SAMPLE_WIDTH 16
// products are scaled back by this many bits
`define COEF_FRAC_BITS 15
// diagonal word after reset, re = 0x7fff and im = 0
`define COEF_UNITY 32'h7fff0000

// clock monitor inputs
`define FREQ_CHANNELS 4
// gate window is 2**FREQ_GATE_BITS dspclk cycles
`define FREQ_GATE_BITS 8
`define FREQ_WIDTH 32

// length of the dsp core reset after the last request
`define RESET_STRETCH 4

`endif

//--- board_pkg.sv
`include "board_defines.svh"

package board_pkg;

	// one coefficient register, written and read back as a raw word,
	// decoded by the mixer as a complex gain
	typedef union packed {
		logic [2*`SAMPLE_WIDTH-1:0] raw;
		struct packed {
			logic signed [`SAMPLE_WIDTH-1:0] re;
			logic signed [`SAMPLE_WIDTH-1:0] im;
		} parts;
	} coef_word_t;

endpackage

//--- chan_mixer.sv
`timescale 1ns/1ps
`include "board_defines.svh"

module chan_mixer import board_pkg::*; (
	input logic dspclk,
	input logic dsp_reset,
	input logic in_stb,
	input logic [`COEF_DIM*`SAMPLE_WIDTH-1:0] in_data,
	output logic busy,
	output logic [`COEF_ADDR_WIDTH-1:0] mix_raddr,
	input coef_word_t mix_rdata,
	output logic out_stb,
	output logic [`COEF_DIM*`SAMPLE_WIDTH-1:0] out_data
);

	localparam int ACC_WIDTH = 40;
	localparam int PROD_WIDTH = 2 * `SAMPLE_WIDTH;
	localparam int IDX_WIDTH = $clog2(`COEF_DIM);
	localparam int LAST_TERM = `COEF_DIM * `COEF_DIM - 1;
	localparam int LAST_COL = `COEF_DIM - 1;
	localparam logic signed [ACC_WIDTH-1:0] SAT_MAX = 2 ** (`SAMPLE_WIDTH - 1) - 1;
	localparam logic signed [ACC_WIDTH-1:0] SAT_MIN = -(2 ** (`SAMPLE_WIDTH - 1));

	logic [`COEF_DIM*`SAMPLE_WIDTH-1:0] frame;
	logic issuing;
	logic [`COEF_ADDR_WIDTH-1:0] term;
	logic rd_valid;
	logic [`COEF_ADDR_WIDTH-1:0] term_d;
	logic [IDX_WIDTH-1:0] col_d;
	logic [IDX_WIDTH-1:0] row_d;
	logic signed [`SAMPLE_WIDTH-1:0] sample;
	logic signed [PROD_WIDTH-1:0] product;
	logic signed [ACC_WIDTH-1:0] acc;
	logic signed [ACC_WIDTH-1:0] acc_base;
	logic signed [ACC_WIDTH-1:0] sum;
	logic signed [ACC_WIDTH-1:0] scaled;
	logic signed [`SAMPLE_WIDTH-1:0] sat_val;
	logic [`COEF_DIM*`SAMPLE_WIDTH-1:0] res;
	logic [`COEF_DIM*`SAMPLE_WIDTH-1:0] res_next;

	// term counter is the row-major coefficient address
	assign mix_raddr = term;

	// term_d lines up with the returned coefficient
	assign col_d = term_d[IDX_WIDTH-1:0];
	assign row_d = term_d[`COEF_ADDR_WIDTH-1:IDX_WIDTH];
	assign sample = frame[col_d*`SAMPLE_WIDTH +: `SAMPLE_WIDTH];
	assign product = mix_rdata.parts.re * sample;

	always_comb begin
		// new row starts from zero
		if (col_d == '0) begin
			acc_base = '0;
		end else begin
			acc_base = acc;
		end
		sum = acc_base + product;

		// floor shift, then clamp to the sample range
		scaled = sum >>> `COEF_FRAC_BITS;
		if (scaled > SAT_MAX) begin
			sat_val = SAT_MAX[`SAMPLE_WIDTH-1:0];
		end else if (scaled < SAT_MIN) begin
			sat_val = SAT_MIN[`SAMPLE_WIDTH-1:0];
		end else begin
			sat_val = scaled[`SAMPLE_WIDTH-1:0];
		end

		res_next = res;
		res_next[row_d*`SAMPLE_WIDTH +: `SAMPLE_WIDTH] = sat_val;
	end

	// control, aborted by dsp_reset
	always_ff @(posedge dspclk) begin
		if (dsp_reset) begin
			busy <= 1'b0;
			issuing <= 1'b0;
			rd_valid <= 1'b0;
			out_stb <= 1'b0;
		end else begin
			out_stb <= 1'b0;
			rd_valid <= issuing;
			if (in_stb && !busy) begin
				busy <= 1'b1;
				issuing <= 1'b1;
			end else if (issuing && term == LAST_TERM) begin
				issuing <= 1'b0;
			end
			// last product lands this cycle
			if (rd_valid && term_d == LAST_TERM) begin
				busy <= 1'b0;
				out_stb <= 1'b1;
			end
		end
	end

	// datapath
	always_ff @(posedge dspclk) begin
		if (in_stb && !busy) begin
			frame <= in_data;
			term <= '0;
		end else if (issuing) begin
			term <= term + 1'b1;
		end
		term_d <= term;
		if (rd_valid) begin
			acc <= sum;
			if (col_d == LAST_COL) begin
				res <= res_next;
			end
			// out_data holds until the next frame completes
			if (term_d == LAST_TERM) begin
				out_data <= res_next;
			end
		end
	end

endmodule

//--- coef_bank.sv
`timescale 1ns/1ps
`include "board_defines.svh"

module coef_bank import board_pkg::*; (
	input logic dspclk,
	input logic reset,
	input logic coef_wstb,
	input logic [`COEF_ADDR_WIDTH-1:0] coef_waddr,
	input coef_word_t coef_wdata,
	input logic [`COEF_ADDR_WIDTH-1:0] mix_raddr,
	output coef_word_t mix_rdata,
	input logic [`COEF_ADDR_WIDTH-1:0] coef_raddr,
	output coef_word_t coef_rdata
);

	localparam int DEPTH = `COEF_DIM * `COEF_DIM;

	// row-major storage
	coef_word_t coef [DEPTH];

	// identity matrix on reset, single write port otherwise
	always_ff @(posedge dspclk) begin
		if (reset) begin
			for (int i = 0; i < DEPTH; i++) begin
				if ((i / `COEF_DIM) == (i % `COEF_DIM)) begin
					coef[i].raw <= `COEF_UNITY;
				end else begin
					coef[i].raw <= '0;
				end
			end
		end else if (coef_wstb) begin
			coef[coef_waddr].raw <= coef_wdata.raw;
		end
	end

	// mixer read port, one cycle latency
	always_ff @(posedge dspclk) begin
		mix_rdata <= coef[mix_raddr];
	end

	// register readback port, also one cycle latency
	always_ff @(posedge dspclk) begin
		if (reset) begin
			coef_rdata.raw <= '0;
		end else begin
			coef_rdata <= coef[coef_raddr];
		end
	end

endmodule

//--- freq_meter.sv
`timescale 1ns/1ps
`include "board_defines.svh"

module freq_meter (
	input logic dspclk,
	input logic reset,
	input logic [`FREQ_CHANNELS-1:0] fin,
	output logic freq_stb,
	output logic [`FREQ_CHANNELS*`FREQ_WIDTH-1:0] freq_data
);

	logic [`FREQ_CHANNELS-1:0] fin_meta;
	logic [`FREQ_CHANNELS-1:0] fin_sync;
	logic [`FREQ_CHANNELS-1:0] fin_prev;
	logic [`FREQ_CHANNELS-1:0] fin_rise;
	logic [`FREQ_GATE_BITS-1:0] gate_cnt;
	logic gate_end;
	logic [`FREQ_WIDTH-1:0] edge_cnt [`FREQ_CHANNELS];
	logic [`FREQ_WIDTH-1:0] edge_next [`FREQ_CHANNELS];

	// monitor inputs are asynchronous to dspclk
	always_ff @(posedge dspclk) begin
		if (reset) begin
			fin_meta <= '0;
			fin_sync <= '0;
			fin_prev <= '0;
		end else begin
			fin_meta <= fin;
			fin_sync <= fin_meta;
			fin_prev <= fin_sync;
		end
	end

	assign fin_rise = fin_sync & ~fin_prev;

	// last cycle of the window
	assign gate_end = &gate_cnt;

	// count including an edge seen in the current cycle
	always_comb begin
		for (int i = 0; i < `FREQ_CHANNELS; i++) begin
			edge_next[i] = edge_cnt[i] + {{(`FREQ_WIDTH-1){1'b0}}, fin_rise[i]};
		end
	end

	always_ff @(posedge dspclk) begin
		if (reset) begin
			gate_cnt <= '0;
			freq_stb <= 1'b0;
			for (int i = 0; i < `FREQ_CHANNELS; i++) begin
				edge_cnt[i] <= '0;
			end
		end else begin
			gate_cnt <= gate_cnt + 1'b1;
			freq_stb <= gate_end;
			for (int i = 0; i < `FREQ_CHANNELS; i++) begin
				if (gate_end) begin
					edge_cnt[i] <= '0;
				end else begin
					edge_cnt[i] <= edge_next[i];
				end
			end
		end
	end

	// all channels update together at the window boundary
	always_ff @(posedge dspclk) begin
		if (gate_end) begin
			for (int i = 0; i < `FREQ_CHANNELS; i++) begin
				freq_data[i*`FREQ_WIDTH +: `FREQ_WIDTH] <= edge_next[i];
			end
		end
	end

endmodule

//--- reset_stretch.sv
`timescale 1ns/1ps
`include "board_defines.svh"

module reset_stretch (
	input logic dspclk,
	input logic reset,
	input logic soft_reset_stb,
	output logic dsp_reset
);

	localparam int CNT_WIDTH = $clog2(`RESET_STRETCH + 1);

	logic [CNT_WIDTH-1:0] cnt;
	logic [CNT_WIDTH-1:0] cnt_next;

	// board reset and the software strobe both reload the counter
	always_comb begin
		if (reset || soft_reset_stb) begin
			cnt_next = CNT_WIDTH'(`RESET_STRETCH);
		end else if (cnt != '0) begin
			cnt_next = cnt - 1'b1;
		end else begin
			cnt_next = '0;
		end
	end

	// registered so dsp_reset follows the counter without glitches
	always_ff @(posedge dspclk) begin
		cnt <= cnt_next;
		dsp_reset <= (cnt_next != '0);
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# compile the board_cfg testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
	--top-module tb_board_cfg \
	-f verilog.f \
	-o sim_board_cfg \
	&& ./obj_dir/sim_board_cfg \
	|| exit 1

//--- tb_board_cfg.sv
`timescale 1ns/1ps
`include "board_defines.svh"

module tb_board_cfg import board_pkg::*; ();

	// all tests together take about 6000 cycles, so this leaves a wide margin
	localparam int TIMEOUT_CYCLES = 20000;
	localparam int MIX_LATENCY = 66;
	localparam int GATE_CYCLES = 2 ** `FREQ_GATE_BITS;
	// half period of each monitor input, in dspclk cycles
	localparam int FIN_HALF [`FREQ_CHANNELS] = '{2, 3, 5, 7};

	logic dspclk;
	logic reset;
	logic [`FREQ_CHANNELS-1:0] fin;
	logic soft_reset_stb;
	logic coef_wstb;
	logic [`COEF_ADDR_WIDTH-1:0] coef_waddr;
	coef_word_t coef_wdata;
	logic [`COEF_ADDR_WIDTH-1:0] coef_raddr;
	logic in_stb;
	logic [`COEF_DIM*`SAMPLE_WIDTH-1:0] in_data;
	logic dsp_reset;
	coef_word_t coef_rdata;
	logic busy;
	logic out_stb;
	logic [`COEF_DIM*`SAMPLE_WIDTH-1:0] out_data;
	logic freq_stb;
	logic [`FREQ_CHANNELS*`FREQ_WIDTH-1:0] freq_data;

	int seed;
	int cycle_cnt;
	int out_count;
	int expected_outs;
	// copy of the coefficient matrix
	coef_word_t model_coef [`COEF_DIM*`COEF_DIM];

	tb_clock tb_clock_inst (
		.dspclk(dspclk)
	);

	board_cfg board_cfg_inst (
		.dspclk(dspclk),
		.reset(reset),
		.fin(fin),
		.soft_reset_stb(soft_reset_stb),
		.coef_wstb(coef_wstb),
		.coef_waddr(coef_waddr),
		.coef_wdata(coef_wdata),
		.coef_raddr(coef_raddr),
		.in_stb(in_stb),
		.in_data(in_data),
		.dsp_reset(dsp_reset),
		.coef_rdata(coef_rdata),
		.busy(busy),
		.out_stb(out_stb),
		.out_data(out_data),
		.freq_stb(freq_stb),
		.freq_data(freq_data)
	);

	task automatic check_value(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		if (actual !== expected) begin
			$display("Fail %s expected 0x%0h actual 0x%0h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	always @(posedge dspclk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	always @(negedge dspclk) begin
		if (out_stb === 1'b1) begin
			out_count <= out_count + 1;
		end
	end

	// monitor inputs toggle with fixed periods of 4, 6, 10 and 14 cycles
	initial begin : fin_gen
		int half_cnt [`FREQ_CHANNELS];
		fin = '0;
		for (int i = 0; i < `FREQ_CHANNELS; i++) begin
			half_cnt[i] = 0;
		end
		forever begin
			@(posedge dspclk);
			for (int i = 0; i < `FREQ_CHANNELS; i++) begin
				if (half_cnt[i] == FIN_HALF[i] - 1) begin
					half_cnt[i] = 0;
					fin[i] <= ~fin[i];
				end else begin
					half_cnt[i]++;
				end
			end
		end
	end

	function automatic logic [127:0] rand_frame();
		logic [127:0] x;
		for (int i = 0; i < 4; i++) begin
			x[i*32 +: 32] = $random(seed);
		end
		return x;
	endfunction

	// floor shift of the row sum, then clamp to 16 bits
	function automatic logic [127:0] model_mix(input logic [127:0] x);
		logic [127:0] y;
		longint acc;
		longint scaled;
		y = '0;
		for (int r = 0; r < `COEF_DIM; r++) begin
			acc = 0;
			for (int c = 0; c < `COEF_DIM; c++) begin
				acc += longint'(model_coef[r*`COEF_DIM + c].parts.re) *
					longint'($signed(x[c*`SAMPLE_WIDTH +: `SAMPLE_WIDTH]));
			end
			scaled = acc >>> `COEF_FRAC_BITS;
			if (scaled > 32767) begin
				y[r*`SAMPLE_WIDTH +: `SAMPLE_WIDTH] = 16'h7fff;
			end else if (scaled < -32768) begin
				y[r*`SAMPLE_WIDTH +: `SAMPLE_WIDTH] = 16'h8000;
			end else begin
				y[r*`SAMPLE_WIDTH +: `SAMPLE_WIDTH] = scaled[15:0];
			end
		end
		return y;
	endfunction

	task automatic write_coef(input logic [`COEF_ADDR_WIDTH-1:0] addr, input coef_word_t data);
		@(posedge dspclk);
		coef_wstb <= 1'b1;
		coef_waddr <= addr;
		coef_wdata <= data;
		model_coef[addr] = data;
	endtask

	// also idles the write port, so a pending write lands first
	task automatic read_back(input logic [`COEF_ADDR_WIDTH-1:0] addr, input logic [31:0] want);
		@(posedge dspclk);
		coef_wstb <= 1'b0;
		coef_raddr <= addr;
		@(posedge dspclk);
		@(negedge dspclk);
		check_value($sformatf("coef_rdata[%0d]", addr), 128'(want), 128'(coef_rdata.raw));
	endtask

	// random matrix, re scaled down by shift bits
	task automatic load_matrix(input int shift);
		coef_word_t w;
		for (int a = 0; a < `COEF_DIM*`COEF_DIM; a++) begin
			w = $random(seed);
			w.parts.re = w.parts.re >>> shift;
			write_coef(`COEF_ADDR_WIDTH'(a), w);
		end
		@(posedge dspclk);
		coef_wstb <= 1'b0;
	endtask

	// inject > 0 gives a second in_stb while busy at that cycle
	task automatic run_frame(input logic [127:0] x, input int inject);
		logic [127:0] want;
		logic [127:0] junk;
		int lat;
		want = model_mix(x);
		junk = rand_frame();
		@(posedge dspclk);
		in_stb <= 1'b1;
		in_data <= x;
		@(posedge dspclk);
		in_stb <= 1'b0;
		lat = 1;
		@(negedge dspclk);
		while (out_stb !== 1'b1) begin
			check_value("busy", 128'(1'b1), 128'(busy));
			@(posedge dspclk);
			lat++;
			if (lat == inject) begin
				in_stb <= 1'b1;
				in_data <= junk;
			end else begin
				in_stb <= 1'b0;
			end
			@(negedge dspclk);
		end
		check_value("out_stb latency", 128'(MIX_LATENCY), 128'(lat));
		check_value("out_data", want, out_data);
		check_value("busy after out_stb", 128'(1'b0), 128'(busy));
		expected_outs++;
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge dspclk);
			check_value("out_stb", 128'(1'b0), 128'(out_stb));
		end
	endtask

	task automatic abort_frame();
		int high_cycles;
		@(posedge dspclk);
		in_stb <= 1'b1;
		in_data <= rand_frame();
		@(posedge dspclk);
		in_stb <= 1'b0;
		repeat (20) @(posedge dspclk);
		@(negedge dspclk);
		check_value("busy before soft reset", 128'(1'b1), 128'(busy));
		@(posedge dspclk);
		soft_reset_stb <= 1'b1;
		@(posedge dspclk);
		soft_reset_stb <= 1'b0;
		high_cycles = 0;
		repeat (12) begin
			@(negedge dspclk);
			if (dsp_reset === 1'b1) begin
				high_cycles++;
			end
			check_value("out_stb in soft reset", 128'(1'b0), 128'(out_stb));
		end
		check_value("dsp_reset cycles", 128'(`RESET_STRETCH), 128'(high_cycles));
		check_value("busy after soft reset", 128'(1'b0), 128'(busy));
		expect_quiet(80);
	endtask

	task automatic measure_freq();
		int last_stb;
		int got;
		int want;
		int bound;
		last_stb = -1;
		repeat (4) begin
			do begin
				@(negedge dspclk);
			end while (freq_stb !== 1'b1);
			for (int ch = 0; ch < `FREQ_CHANNELS; ch++) begin
				got = int'(freq_data[ch*`FREQ_WIDTH +: `FREQ_WIDTH]);
				want = GATE_CYCLES / (2 * FIN_HALF[ch]);
				// nearest end of the +-1 window
				if (got > want + 1) begin
					bound = want + 1;
				end else if (got < want - 1) begin
					bound = want - 1;
				end else begin
					bound = got;
				end
				check_value($sformatf("freq_data[%0d]", ch), 128'(bound), 128'(got));
			end
			if (last_stb >= 0) begin
				check_value("freq_stb spacing", 128'(GATE_CYCLES), 128'(cycle_cnt - last_stb));
			end
			last_stb = cycle_cnt;
		end
	endtask

	initial begin
		seed = 50759;
		reset = 1'b1;
		soft_reset_stb = 1'b0;
		coef_wstb = 1'b0;
		coef_waddr = '0;
		coef_wdata = '0;
		coef_raddr = '0;
		in_stb = 1'b0;
		in_data = '0;
		for (int a = 0; a < `COEF_DIM*`COEF_DIM; a++) begin
			model_coef[a].raw = (a / `COEF_DIM == a % `COEF_DIM) ? `COEF_UNITY : 32'h0;
		end

		// readback stays zero while reset is high
		repeat (2) @(posedge dspclk);
		@(negedge dspclk);
		check_value("coef_rdata in reset", 128'(1'b0), 128'(coef_rdata.raw));
		repeat (2) @(posedge dspclk);
		reset <= 1'b0;
		do begin
			@(negedge dspclk);
		end while (dsp_reset !== 1'b0);

		// identity after reset
		for (int a = 0; a < `COEF_DIM*`COEF_DIM; a++) begin
			read_back(`COEF_ADDR_WIDTH'(a),
				(a / `COEF_DIM == a % `COEF_DIM) ? `COEF_UNITY : 32'h0);
		end
		run_frame(rand_frame(), 0);

		// single writes with readback
		repeat (40) begin : write_test
			logic [`COEF_ADDR_WIDTH-1:0] addr;
			coef_word_t w;
			addr = `COEF_ADDR_WIDTH'($random(seed));
			w = $random(seed);
			write_coef(addr, w);
			read_back(addr, w.raw);
		end

		for (int f = 0; f < 30; f++) begin
			load_matrix((f % 3) * 4);
			run_frame(rand_frame(), 0);
		end

		// extra in_stb while busy
		for (int k = 0; k < 4; k++) begin
			run_frame(rand_frame(), 3 + 14 * k);
			expect_quiet(80);
		end

		abort_frame();
		run_frame(rand_frame(), 0);

		measure_freq();
		check_value("out_stb count", 128'(expected_outs), 128'(out_count));

		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic dspclk
);

	// 8 ns period
	localparam real HALF_PERIOD = 4.0;

	initial begin
		dspclk = 1'b0;
		forever #HALF_PERIOD dspclk = ~dspclk;
	end

endmodule

//--- verilog.f
+incdir+.
board_pkg.sv
reset_stretch.sv
freq_meter.sv
coef_bank.sv
chan_mixer.sv
board_cfg.sv
tb_clock.sv
tb_board_cfg.sv
